//--- Makefile
# Verilator build and run of the z80 io port block testbench

VERILATOR ?= verilator
TOP       ?= zports_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+verification
hdl/z80_bus_pkg.sv
hdl/zx_regs_pkg.sv
hdl/z80_io_if.sv
hdl/z80_io_decode.sv
hdl/pent_port_regs.sv
hdl/ide_seq_fsm.sv
hdl/ide_data_path.sv
hdl/io_read_mux.sv
hdl/zports_top.sv
verification/zports_tb.sv

//--- hdl/ide_data_path.sv
// Ide data path: write word register, saved high byte of a drive read,
// and the muxes toward the drive and toward the z80.

module ide_data_path (
	input  logic                   zclk,
	input  logic                   rst_n,
	z80_io_if.ide                  io,
	input  zx_regs_pkg::ide_word_t idein,
	input  logic                   rd_hi_sel,
	input  logic                   wr_lo_held,
	input  logic                   wr_hi_held,
	input  logic                   hi_capture,
	output zx_regs_pkg::ide_word_t ideout,
	output z80_bus_pkg::byte_t     ide_rd_even,
	output z80_bus_pkg::byte_t     ide_rd_odd
);

	zx_regs_pkg::ide_word_t wr_word; // one half prewritten here
	z80_bus_pkg::byte_t     hi_in;   // high half of last drive read

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_word <= '0;
			hi_in   <= '0;
		end
		else
		begin
			if (io.port_wr && (io.sel == z80_bus_pkg::SEL_IDE_HI))
				wr_word[15:8] <= io.din; // normal order, high first
			// low half, unless this is the second divide write
			if (io.port_wr && (io.sel == z80_bus_pkg::SEL_IDE_LO) && !wr_lo_held)
				wr_word[7:0] <= io.din;
			if (hi_capture)
				hi_in <= idein[15:8];
		end
	end

	// toward the drive, stored half plus live bus byte
	assign ideout[15:8] = wr_hi_held ? wr_word[15:8] : io.din;
	assign ideout[7:0]  = wr_lo_held ? wr_word[7:0] : io.din;

	// toward the z80
	assign ide_rd_even = rd_hi_sel ? hi_in : idein[7:0];
	assign ide_rd_odd  = hi_in; // port 11

endmodule

//--- hdl/ide_seq_fsm.sv
// Nemo ide access sequencer: read and write triggers for the divide order.
// Drives the ide chip selects and strobes, and steers the ide data path.

module ide_seq_fsm (
	input  logic   zclk,
	input  logic   rst_n,
	z80_io_if.ide  io,
	output logic   rd_hi_sel,
	output logic   wr_lo_held,
	output logic   wr_hi_held,
	output logic   hi_capture,
	output logic   ide_cs0_n,
	output logic   ide_cs1_n,
	output logic   ide_rd_n,
	output logic   ide_wr_n,
	output logic   idedataout
);

	logic ide_ports; // ports that reach the drive
	logic any_ide;   // the same plus port 11
	logic is_10;
	logic io_pulse;

	logic rd_trig, wrlo_trig, wrhi_trig; // sequencer state
	logic rd_held;                       // rd_trig frozen for the bus cycle

	assign is_10     = (io.sel == z80_bus_pkg::SEL_IDE_LO);
	assign ide_ports = is_10 | (io.sel == z80_bus_pkg::SEL_IDE_REG) |
	                   (io.sel == z80_bus_pkg::SEL_IDE_CTL);
	assign any_ide   = ide_ports | (io.sel == z80_bus_pkg::SEL_IDE_HI);
	assign io_pulse  = io.port_rd | io.port_wr;

	// first read of 10 fetches the drive word, keeps high half
	assign hi_capture = io.port_rd & is_10 & ~rd_trig;

	////////////////////////////////////////////////////////////////////////////
	// triggers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_trig   <= 1'b0;
			wrlo_trig <= 1'b0;
			wrhi_trig <= 1'b0;
		end
		else if (any_ide && io_pulse)
		begin
			rd_trig   <= hi_capture; // any other ide access clears it
			wrhi_trig <= io.port_wr & (io.sel == z80_bus_pkg::SEL_IDE_HI);
			wrlo_trig <= io.port_wr & is_10 & ~wrhi_trig & ~wrlo_trig; // divide 1st half
		end
	end

	// hold trigger values while the strobe is low
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_held    <= 1'b0;
			wr_lo_held <= 1'b0;
			wr_hi_held <= 1'b0;
		end
		else
		begin
			if (io.rd_n)
				rd_held <= rd_trig;
			if (io.wr_n)
			begin
				wr_lo_held <= wrlo_trig;
				wr_hi_held <= wrhi_trig;
			end
		end
	end

	// divide read, second read of 10 takes the saved half
	assign rd_hi_sel = rd_held & is_10;

	assign ide_cs0_n = ~ide_ports | (io.sel == z80_bus_pkg::SEL_IDE_CTL);
	assign ide_cs1_n = (io.sel != z80_bus_pkg::SEL_IDE_CTL);

	assign ide_rd_n = io.iorq_n | io.rd_n | ~ide_ports | rd_hi_sel;
	// no drive write on the low half of a divide write
	assign ide_wr_n = io.iorq_n | io.wr_n | ~ide_ports | (is_10 & ~wr_lo_held & ~wr_hi_held);

	assign idedataout = ide_rd_n; // fpga drives ide data unless reading

endmodule

//--- hdl/io_read_mux.sv
// Byte the z80 reads from the decoded port.
// Everything not readable here floats to FF.

module io_read_mux (
	input  z80_bus_pkg::port_sel_e sel,
	input  logic [4:0]             keys_in,
	input  logic                   tape_read,
	input  z80_bus_pkg::byte_t     ide_rd_even,
	input  z80_bus_pkg::byte_t     ide_rd_odd,
	output z80_bus_pkg::byte_t     dout
);

	always_comb
	begin
		case (sel)
			z80_bus_pkg::SEL_FE:
				dout = {1'b1, tape_read, 1'b0, keys_in}; // keyboard row + tape in
			z80_bus_pkg::SEL_IDE_LO,
			z80_bus_pkg::SEL_IDE_REG,
			z80_bus_pkg::SEL_IDE_CTL:
				dout = ide_rd_even;
			z80_bus_pkg::SEL_IDE_HI:
				dout = ide_rd_odd;
			// 7FFD and EFF7 are write only
			default:
				dout = z80_bus_pkg::READ_IDLE;
		endcase
	end

endmodule

//--- hdl/pent_port_regs.sv
// FE, 7FFD and EFF7 port registers.
// Applies the 48k lock and the 1 MB block, and forms the paging outputs.

module pent_port_regs (
	input  logic                                zclk,
	input  logic                                rst_n,
	z80_io_if.regs                              io,
	output logic [zx_regs_pkg::BORDER_W-1:0]    border,
	output logic                                beep,
	output z80_bus_pkg::byte_t                  p7ffd,
	output z80_bus_pkg::byte_t                  peff7,
	output zx_regs_pkg::page_t                  pent1m_page,
	output logic                                pent1m_rom,
	output logic                                pent1m_1m_on,
	output logic                                pent1m_ram0_0
);

	z80_bus_pkg::byte_t p7ffd_q, peff7_q;

	logic block1m;   // eff7.2, plain 128k mode
	logic block7ffd; // 7ffd frozen

	assign block1m   = peff7_q[zx_regs_pkg::BEFF7_BLOCK1M];
	assign block7ffd = p7ffd_q[zx_regs_pkg::B7FFD_BLOCK48] & block1m; // lock only in 128k mode

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border  <= zx_regs_pkg::BORDER_RST;
			beep    <= 1'b0;
			p7ffd_q <= zx_regs_pkg::P7FFD_RST;
			peff7_q <= zx_regs_pkg::PEFF7_RST;
		end
		else if (io.port_wr)
		begin
			// FE port
			if (io.sel == z80_bus_pkg::SEL_FE)
			begin
				border <= io.din[zx_regs_pkg::BORDER_W-1:0];
				beep   <= io.din[4] ^ io.din[3]; // beeper and tape out share one pin
			end
			if ((io.sel == z80_bus_pkg::SEL_7FFD) && !block7ffd)
				p7ffd_q <= io.din;
			if (io.sel == z80_bus_pkg::SEL_EFF7)
				peff7_q <= io.din;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// paging outputs
	////////////////////////////////////////////////////////////////////////////

	// high page bits vanish in 128k mode
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), p7ffd_q[4:0]};

	// 128k mode keeps turbo, 16c and 7/5/4 only
	assign peff7 = block1m ? {peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;

	assign pent1m_page   = {p7ffd_q[7:5], p7ffd_q[2:0]}; // full 1M page
	assign pent1m_rom    = p7ffd_q[4];
	assign pent1m_1m_on  = ~block1m;
	assign pent1m_ram0_0 = peff7_q[zx_regs_pkg::BEFF7_RAM0];

endmodule

//--- hdl/z80_bus_pkg.sv
// Z80 bus types, I/O port addresses and the decoded port code.
// Shared by the port decoder, the read mux and the testbench.

package z80_bus_pkg;

	typedef logic [7:0]  byte_t;    // data bus byte
	typedef logic [15:0] addr_t;    // full z80 address
	typedef logic [7:0]  port_lo_t; // a[7:0], selects the port

	////////////////////////////////////////////////////////////////////////////
	// port addresses, low byte only
	////////////////////////////////////////////////////////////////////////////

	localparam port_lo_t PORT_FE = 8'hFE; // border, beeper, keyboard
	localparam port_lo_t PORT_FD = 8'hFD; // 7FFD paging
	localparam port_lo_t PORT_F7 = 8'hF7; // EFF7 paging

	// nemo ide, one port per task file register
	localparam port_lo_t IDE_10 = 8'h10; // data, low byte
	localparam port_lo_t IDE_11 = 8'h11; // data, high byte
	localparam port_lo_t IDE_30 = 8'h30;
	localparam port_lo_t IDE_50 = 8'h50;
	localparam port_lo_t IDE_70 = 8'h70;
	localparam port_lo_t IDE_90 = 8'h90;
	localparam port_lo_t IDE_B0 = 8'hB0;
	localparam port_lo_t IDE_D0 = 8'hD0;
	localparam port_lo_t IDE_F0 = 8'hF0;
	localparam port_lo_t IDE_C8 = 8'hC8; // control block, cs1

	// what the decoder found on the bus
	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_FE,
		SEL_7FFD,    // a15 clear
		SEL_EFF7,    // a12 clear, shadow off
		SEL_IDE_LO,
		SEL_IDE_HI,
		SEL_IDE_REG, // 30..F0
		SEL_IDE_CTL
	} port_sel_e;

	localparam byte_t READ_IDLE = 8'hFF; // floating bus value

endpackage

//--- hdl/z80_io_decode.sv
// Z80 io strobe edge detection and port decoding.
// Makes the one-cycle port pulses and drives porthit and dataout.

module z80_io_decode (
	input  logic               zclk,
	input  logic               rst_n,
	input  z80_bus_pkg::addr_t a,
	input  z80_bus_pkg::byte_t din,
	input  logic               iorq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               dos,
	z80_io_if.src              io,
	output logic               porthit,
	output logic               dataout
);

	z80_bus_pkg::port_lo_t loa;

	logic iowr_now, iord_now; // strobe pair active right now
	logic iowr_q, iord_q;     // same, one edge ago
	logic shadow;

	assign loa    = a[7:0];
	assign shadow = dos; // no BF port here, dos only

	// pass the bus through to the port blocks
	assign io.a_hi   = a[15:8];
	assign io.din    = din;
	assign io.rd_n   = rd_n;
	assign io.wr_n   = wr_n;
	assign io.iorq_n = iorq_n;

	assign iowr_now = ~(iorq_n | wr_n);
	assign iord_now = ~(iorq_n | rd_n);

	////////////////////////////////////////////////////////////////////////////
	// strobe edges
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_q     <= 1'b0;
			iord_q     <= 1'b0;
			io.port_wr <= 1'b0;
			io.port_rd <= 1'b0;
		end
		else
		begin
			iowr_q     <= iowr_now;
			iord_q     <= iord_now;
			io.port_wr <= iowr_now & ~iowr_q; // first edge of the cycle only
			io.port_rd <= iord_now & ~iord_q;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		io.sel = z80_bus_pkg::SEL_NONE;
		case (loa)
			z80_bus_pkg::PORT_FE: io.sel = z80_bus_pkg::SEL_FE;
			z80_bus_pkg::PORT_FD: if (!io.a_hi[7]) io.sel = z80_bus_pkg::SEL_7FFD; // 7FFD
			z80_bus_pkg::PORT_F7:
				if (!io.a_hi[4] && !shadow)
					io.sel = z80_bus_pkg::SEL_EFF7; // EFF7, hidden under dos
			z80_bus_pkg::IDE_10: io.sel = z80_bus_pkg::SEL_IDE_LO;
			z80_bus_pkg::IDE_11: io.sel = z80_bus_pkg::SEL_IDE_HI;
			z80_bus_pkg::IDE_30, z80_bus_pkg::IDE_50, z80_bus_pkg::IDE_70,
			z80_bus_pkg::IDE_90, z80_bus_pkg::IDE_B0, z80_bus_pkg::IDE_D0,
			z80_bus_pkg::IDE_F0: io.sel = z80_bus_pkg::SEL_IDE_REG;
			z80_bus_pkg::IDE_C8: io.sel = z80_bus_pkg::SEL_IDE_CTL;
			default: io.sel = z80_bus_pkg::SEL_NONE;
		endcase
	end

	// zxbus sees our ports only during an io cycle
	assign porthit = (io.sel != z80_bus_pkg::SEL_NONE) & ~iorq_n;
	assign dataout = (io.sel != z80_bus_pkg::SEL_NONE) & ~iorq_n & ~rd_n; // we drive the bus

endmodule

//--- hdl/z80_io_if.sv
// Decoded z80 port access, from the decoder to the register and ide blocks.
// Carries the port code, the bus byte, the port pulses and the raw strobes.

interface z80_io_if;

	z80_bus_pkg::port_sel_e sel; // decoded port
	z80_bus_pkg::byte_t     a_hi; // a[15:8]
	z80_bus_pkg::byte_t     din;

	logic port_rd; // one zclk per io read
	logic port_wr; // one zclk per io write

	logic rd_n;   // raw bus levels
	logic wr_n;
	logic iorq_n;

	modport src (output sel, a_hi, din, port_rd, port_wr, rd_n, wr_n, iorq_n);

	modport regs (input sel, din, port_wr);

	modport ide (input sel, din, port_rd, port_wr, rd_n, wr_n, iorq_n);

endinterface

//--- hdl/zports_top.sv
// Z80 io port block, top level.
// Connects the decoder, the port registers, the ide blocks and the read mux.

module zports_top (
	input  logic                             zclk,
	input  logic                             rst_n,
	input  z80_bus_pkg::addr_t               a,
	input  z80_bus_pkg::byte_t               din,
	input  logic                             iorq_n,
	input  logic                             rd_n,
	input  logic                             wr_n,
	input  logic                             dos,
	input  logic                             tape_read,
	input  logic [4:0]                       keys_in,
	input  zx_regs_pkg::ide_word_t           idein,
	output z80_bus_pkg::byte_t               dout,
	output logic                             dataout,
	output logic                             porthit,
	output logic [zx_regs_pkg::BORDER_W-1:0] border,
	output logic                             beep,
	output z80_bus_pkg::byte_t               p7ffd,
	output z80_bus_pkg::byte_t               peff7,
	output zx_regs_pkg::page_t               pent1m_page,
	output logic                             pent1m_rom,
	output logic                             pent1m_1m_on,
	output logic                             pent1m_ram0_0,
	output zx_regs_pkg::ide_word_t           ideout,
	output logic [2:0]                       ide_a,
	output logic                             ide_cs0_n,
	output logic                             ide_cs1_n,
	output logic                             ide_rd_n,
	output logic                             ide_wr_n,
	output logic                             idedataout
);

	logic rd_hi_sel, wr_lo_held, wr_hi_held, hi_capture; // sequencer to data path

	z80_bus_pkg::byte_t ide_rd_even, ide_rd_odd;

	z80_io_if io ();

	assign ide_a = a[7:5]; // task file register number

	z80_io_decode decode_i (.zclk, .rst_n, .a, .din, .iorq_n, .rd_n, .wr_n, .dos,
		.io(io.src), .porthit, .dataout);

	pent_port_regs regs_i (.zclk, .rst_n, .io(io.regs), .border, .beep, .p7ffd, .peff7,
		.pent1m_page, .pent1m_rom, .pent1m_1m_on, .pent1m_ram0_0);

	ide_seq_fsm ide_seq_i (.zclk, .rst_n, .io(io.ide), .rd_hi_sel, .wr_lo_held, .wr_hi_held,
		.hi_capture, .ide_cs0_n, .ide_cs1_n, .ide_rd_n, .ide_wr_n, .idedataout);

	ide_data_path ide_data_i (.zclk, .rst_n, .io(io.ide), .idein, .rd_hi_sel, .wr_lo_held,
		.wr_hi_held, .hi_capture, .ideout, .ide_rd_even, .ide_rd_odd);

	io_read_mux read_mux_i (.sel(io.sel), .keys_in, .tape_read, .ide_rd_even, .ide_rd_odd,
		.dout);

endmodule

//--- hdl/zx_regs_pkg.sv
// Paging register layout, ide word types and register reset values.
// Used by the port registers, the ide data path and the top level.

package zx_regs_pkg;

	typedef logic [15:0] ide_word_t; // 16-bit ide data word
	typedef logic [5:0]  page_t;     // pentagon-1m page number

	////////////////////////////////////////////////////////////////////////////
	// 7FFD bits
	////////////////////////////////////////////////////////////////////////////

	// 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 extra page bits
	localparam int B7FFD_BLOCK48 = 5;

	////////////////////////////////////////////////////////////////////////////
	// EFF7 bits
	////////////////////////////////////////////////////////////////////////////

	localparam int BEFF7_BLOCK1M = 2; // set = plain 128k paging
	localparam int BEFF7_RAM0    = 3; // ram at 0000

	localparam int BORDER_W = 3; // border colour bits

	// reset contents
	localparam z80_bus_pkg::byte_t P7FFD_RST = 8'h00;
	localparam z80_bus_pkg::byte_t PEFF7_RST = 8'h00;

	localparam logic [BORDER_W-1:0] BORDER_RST = '0;

endpackage

//--- verification/zports_tb_tasks.svh
// Z80 io cycle tasks and typed compare tasks for the port block testbench.
// Included inside the testbench module, after its signal declarations.

////////////////////////////////////////////////////////////////////////////
// z80 io cycle of 3 active clocks and 1 idle
////////////////////////////////////////////////////////////////////////////

// called 5 ns after a rising edge
task automatic bus_start(input logic wr, input z80_bus_pkg::addr_t addr,
	input z80_bus_pkg::byte_t data);
	a      = addr;
	din    = data; // harmless on reads
	iorq_n = 1'b0;
	rd_n   = wr;
	wr_n   = ~wr;
endtask

task automatic reach_sample();
	repeat (2) @(posedge zclk); // port pulse and then register load
	@(negedge zclk);
endtask

task automatic bus_release();
	@(posedge zclk);
	#5;
	iorq_n = 1'b1;
	rd_n   = 1'b1;
	wr_n   = 1'b1;
	@(posedge zclk); // idle clock
	#5;
endtask

////////////////////////////////////////////////////////////////////////////
// compare tasks per result type
////////////////////////////////////////////////////////////////////////////

task automatic check_byte(input z80_bus_pkg::byte_t got, input z80_bus_pkg::byte_t exp,
	input string what);
	if (got !== exp)
	begin
		$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_word(input zx_regs_pkg::ide_word_t got,
	input zx_regs_pkg::ide_word_t exp, input string what);
	if (got !== exp)
	begin
		$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_page(input zx_regs_pkg::page_t got, input zx_regs_pkg::page_t exp,
	input string what);
	if (got !== exp)
	begin
		$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
	if (got !== exp)
	begin
		$display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		abort_run();
	end
endtask

////////////////////////////////////////////////////////////////////////////
// result checks per table kind
////////////////////////////////////////////////////////////////////////////

task automatic fe_checks(input logic wr);
	if (wr)
	begin
		check_byte(z80_bus_pkg::byte_t'(border), z80_bus_pkg::byte_t'(m_border), "border");
		check_bit(beep, m_beep, "beep");
	end
	else
	begin
		check_byte(dout, {1'b1, tape_read, 1'b0, keys_in}, "fe read");
		check_bit(porthit, 1'b1, "porthit on fe read");
		check_bit(dataout, 1'b1, "dataout on fe read");
	end
endtask

task automatic paging_checks();
	z80_bus_pkg::byte_t exp_7ffd;
	z80_bus_pkg::byte_t exp_eff7;
	exp_7ffd = m_eff7[2] ? {3'b000, m_7ffd[4:0]} : m_7ffd; // 128k mode hides 7..5
	exp_eff7 = m_eff7[2] ? (m_eff7 & 8'hB1) : m_eff7;      // keeps 7 5 4 and 0
	check_byte(p7ffd, exp_7ffd, "p7ffd");
	check_byte(peff7, exp_eff7, "peff7");
	check_page(pent1m_page, {m_7ffd[7:5], m_7ffd[2:0]}, "pent1m_page");
	check_bit(pent1m_1m_on, ~m_eff7[2], "pent1m_1m_on");
	check_bit(pent1m_rom, m_7ffd[4], "pent1m_rom");
	check_bit(pent1m_ram0_0, m_eff7[3], "pent1m_ram0_0");
endtask

task automatic ide_data_checks(input logic wr, input z80_bus_pkg::port_lo_t lo,
	input z80_bus_pkg::byte_t data);
	if (!wr && lo == z80_bus_pkg::IDE_10)
	begin
		check_byte(dout, rd_pend ? save_hi : idein[7:0], "ide port 10 read");
		check_bit(ide_rd_n, rd_pend, "ide_rd_n on port 10 read"); // no drive read 2nd time
	end
	else if (!wr)
	begin
		check_byte(dout, save_hi, "ide port 11 read");
		check_bit(ide_rd_n, 1'b1, "ide_rd_n on port 11 read");
	end
	else if (lo == z80_bus_pkg::IDE_11 || (!whi_pend && !wlo_pend))
		check_bit(ide_wr_n, 1'b1, "ide_wr_n on a held half");
	else
	begin
		check_bit(ide_wr_n, 1'b0, "ide_wr_n on word write");
		check_word(ideout, whi_pend ? {keep_hi, data} : {data, keep_lo}, "ideout");
	end
endtask

task automatic chip_select_checks(input logic wr, input z80_bus_pkg::port_lo_t lo);
	logic exp_cs1_n;
	exp_cs1_n = (lo != z80_bus_pkg::IDE_C8); // control block only
	check_bit(ide_cs1_n, exp_cs1_n, "ide_cs1_n");
	check_bit(ide_cs0_n, ~exp_cs1_n, "ide_cs0_n");
	check_byte(z80_bus_pkg::byte_t'(ide_a), z80_bus_pkg::byte_t'(lo[7:5]), "ide_a");
	if (wr)
	begin
		check_bit(ide_wr_n, 1'b0, "ide_wr_n on task file write");
		check_bit(idedataout, 1'b1, "idedataout on task file write");
	end
	else
	begin
		check_bit(ide_rd_n, 1'b0, "ide_rd_n on task file read");
		check_bit(idedataout, 1'b0, "idedataout on task file read"); // drive owns the bus
		check_byte(dout, idein[7:0], "task file read");
	end
endtask

task automatic idle_read_checks();
	check_byte(dout, z80_bus_pkg::READ_IDLE, "unmapped read");
	check_bit(porthit, 1'b0, "porthit on unmapped port");
	check_bit(dataout, 1'b0, "dataout on unmapped port");
endtask

//--- verification/zports_tb.sv
// Testbench for the z80 io port block. Runs a table of io cycles through the DUT
// and checks every response against a model of the port and paging rules.

module zports_tb;

	timeunit 1ns;
	timeprecision 1ns;

	typedef enum logic [2:0] {CK_FE, CK_PAGE, CK_IDE, CK_CS, CK_IDLE} check_e;

	typedef struct packed {
		logic               wr;   // 1 = io write
		logic               dos;  // dos level during the cycle
		logic               rnd;  // write data from the lfsr
		z80_bus_pkg::byte_t data; // fixed write data
		z80_bus_pkg::addr_t addr;
		check_e             kind;
	} op_t;

	localparam logic RD  = 1'b0;
	localparam logic WR  = 1'b1;
	localparam logic FIX = 1'b0;
	localparam logic RND = 1'b1;

	localparam int RESET_CYCLES = 5;

	// dut pins
	logic                             zclk = 1'b0;
	logic                             rst_n;
	z80_bus_pkg::addr_t               a;
	z80_bus_pkg::byte_t               din;
	logic                             iorq_n, rd_n, wr_n, dos, tape_read;
	logic [4:0]                       keys_in;
	zx_regs_pkg::ide_word_t           idein;
	z80_bus_pkg::byte_t               dout, p7ffd, peff7;
	logic                             dataout, porthit, beep;
	logic [zx_regs_pkg::BORDER_W-1:0] border;
	zx_regs_pkg::page_t               pent1m_page;
	logic                             pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	zx_regs_pkg::ide_word_t           ideout;
	logic [2:0]                       ide_a;
	logic                             ide_cs0_n, ide_cs1_n, ide_rd_n, ide_wr_n, idedataout;

	// reference model state
	logic [zx_regs_pkg::BORDER_W-1:0] m_border;
	logic                             m_beep;
	z80_bus_pkg::byte_t               m_7ffd, m_eff7;
	logic                             rd_pend, wlo_pend, whi_pend; // ide triggers
	z80_bus_pkg::byte_t               save_hi, keep_lo, keep_hi;

	op_t         ops[$];
	logic [15:0] lfsr = 16'd52137;
	int          cycles = 0;
	int          cycle_limit;

	zports_top zports_top_i (.*);

	always #50 zclk = ~zclk; // 100 ns period

	// limit scales with the table length
	always @(posedge zclk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout, the table did not finish within %0d clock cycles", cycle_limit);
			abort_run();
		end
	end

	`include "zports_tb_tasks.svh"

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// fibonacci lfsr x^16+x^14+x^13+x^11 stepped once per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		logic        fb;
		int          i;
		r = '0;
		for (i = 0; i < n; i++)
		begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r    = {r[14:0], fb};
		end
		return r;
	endfunction

	task automatic add_op(input logic wr, input logic dos_lvl, input logic rnd,
		input z80_bus_pkg::byte_t data, input z80_bus_pkg::addr_t addr, input check_e kind);
		ops.push_back(op_t'{wr, dos_lvl, rnd, data, addr, kind});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic load_table();
		//     dir dos   data src  value  address   check
		add_op(WR, 1'b0, RND, 8'h00, 16'h00FE, CK_FE);
		add_op(RD, 1'b0, FIX, 8'h00, 16'h00FE, CK_FE);
		add_op(WR, 1'b0, RND, 8'h00, 16'h7FFE, CK_FE);   // high byte is don't care
		add_op(RD, 1'b0, FIX, 8'h00, 16'hBFFE, CK_FE);
		add_op(WR, 1'b0, RND, 8'h00, 16'h00FE, CK_FE);
		add_op(WR, 1'b0, RND, 8'h00, 16'h7FFD, CK_PAGE);
		add_op(WR, 1'b0, FIX, 8'h00, 16'hEFF7, CK_PAGE); // 1M paging on
		add_op(WR, 1'b0, FIX, 8'hC5, 16'h7FFD, CK_PAGE);
		add_op(WR, 1'b0, FIX, 8'hFD, 16'hEFF7, CK_PAGE); // 1M blocked
		add_op(WR, 1'b0, FIX, 8'h20, 16'h7FFD, CK_PAGE); // sets the 48k lock
		add_op(WR, 1'b0, FIX, 8'h07, 16'h7FFD, CK_PAGE); // locked out
		add_op(WR, 1'b1, FIX, 8'h00, 16'hEFF7, CK_PAGE); // eff7 hidden under dos
		add_op(WR, 1'b0, FIX, 8'h00, 16'hEFF7, CK_PAGE);
		add_op(WR, 1'b0, RND, 8'h00, 16'h7FFD, CK_PAGE);
		add_op(RD, 1'b0, FIX, 8'h00, 16'h0010, CK_IDE);  // normal read order
		add_op(RD, 1'b0, FIX, 8'h00, 16'h0011, CK_IDE);
		add_op(WR, 1'b0, RND, 8'h00, 16'h0011, CK_IDE);  // normal write order
		add_op(WR, 1'b0, RND, 8'h00, 16'h0010, CK_IDE);
		add_op(RD, 1'b0, FIX, 8'h00, 16'h0010, CK_IDE);  // divide read
		add_op(RD, 1'b0, FIX, 8'h00, 16'h0010, CK_IDE);
		add_op(WR, 1'b0, RND, 8'h00, 16'h0010, CK_IDE);  // divide write
		add_op(WR, 1'b0, RND, 8'h00, 16'h0010, CK_IDE);
		add_op(WR, 1'b0, RND, 8'h00, 16'h0010, CK_IDE);  // low half only
		add_op(RD, 1'b0, FIX, 8'h00, 16'h0030, CK_CS);   // drops the pending half
		add_op(WR, 1'b0, RND, 8'h00, 16'h0010, CK_IDE);
		add_op(WR, 1'b0, RND, 8'h00, 16'h0010, CK_IDE);
		add_op(RD, 1'b0, FIX, 8'h00, 16'h00C8, CK_CS);
		add_op(WR, 1'b0, RND, 8'h00, 16'h0030, CK_CS);
		add_op(RD, 1'b0, FIX, 8'h00, 16'h0090, CK_CS);
		add_op(WR, 1'b0, RND, 8'h00, 16'h00C8, CK_CS);
		add_op(RD, 1'b0, FIX, 8'h00, 16'h00FF, CK_IDLE);
		add_op(RD, 1'b0, FIX, 8'h00, 16'hFFFD, CK_IDLE); // a15 set so not 7ffd
		add_op(RD, 1'b0, FIX, 8'h00, 16'h0012, CK_IDLE);
		add_op(RD, 1'b0, FIX, 8'h00, 16'h10F7, CK_IDLE); // a12 set so not eff7
		add_op(RD, 1'b1, FIX, 8'h00, 16'hEFF7, CK_IDLE);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic regs_model(input op_t op, input z80_bus_pkg::byte_t data);
		if (op.wr)
		begin
			case (op.addr[7:0])
				z80_bus_pkg::PORT_FE:
				begin
					m_border = data[zx_regs_pkg::BORDER_W-1:0];
					m_beep   = data[4] ^ data[3];
				end
				z80_bus_pkg::PORT_FD:
					if (!op.addr[15] && !(m_7ffd[5] && m_eff7[2]))
						m_7ffd = data; // unless locked
				z80_bus_pkg::PORT_F7:
					if (!op.addr[12] && !op.dos)
						m_eff7 = data;
				default: ;
			endcase
		end
	endtask

	task automatic ide_trigger_model(input logic wr, input z80_bus_pkg::port_lo_t lo,
		input z80_bus_pkg::byte_t data);
		logic fresh; // no write half pending
		fresh = !wlo_pend && !whi_pend;
		if (lo == z80_bus_pkg::IDE_10 && !wr)
		begin
			if (!rd_pend)
				save_hi = idein[15:8]; // drive word fetched and high half kept
			rd_pend  = !rd_pend;
			wlo_pend = 1'b0;
			whi_pend = 1'b0;
		end
		else if (lo == z80_bus_pkg::IDE_10)
		begin
			if (fresh)
				keep_lo = data;
			wlo_pend = fresh;
			whi_pend = 1'b0;
			rd_pend  = 1'b0;
		end
		else if (lo == z80_bus_pkg::IDE_11 && wr)
		begin
			keep_hi  = data;
			whi_pend = 1'b1;
			wlo_pend = 1'b0;
			rd_pend  = 1'b0;
		end
		else if (lo inside {z80_bus_pkg::IDE_11, z80_bus_pkg::IDE_30, z80_bus_pkg::IDE_50,
			z80_bus_pkg::IDE_70, z80_bus_pkg::IDE_90, z80_bus_pkg::IDE_B0,
			z80_bus_pkg::IDE_D0, z80_bus_pkg::IDE_F0, z80_bus_pkg::IDE_C8})
		begin
			rd_pend  = 1'b0; // any other ide access
			wlo_pend = 1'b0;
			whi_pend = 1'b0;
		end
	endtask

	task automatic run_op(input op_t op);
		z80_bus_pkg::byte_t data;
		data      = op.rnd ? z80_bus_pkg::byte_t'(rand_bits(8)) : op.data;
		keys_in   = 5'(rand_bits(5));
		tape_read = 1'(rand_bits(1));
		idein     = rand_bits(16);
		dos       = op.dos;
		bus_start(op.wr, op.addr, data);
		reach_sample();
		regs_model(op, data);
		case (op.kind)
			CK_FE:   fe_checks(op.wr);
			CK_PAGE: paging_checks();
			CK_IDE:  ide_data_checks(op.wr, op.addr[7:0], data);
			CK_CS:   chip_select_checks(op.wr, op.addr[7:0]);
			default: idle_read_checks();
		endcase
		ide_trigger_model(op.wr, op.addr[7:0], data);
		bus_release();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		rst_n     = 1'b0;
		a         = 16'h0030; // task file port with the strobes idle
		din       = '0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		tape_read = 1'b0;
		keys_in   = '0;
		idein     = '0;
		m_border  = '0;
		m_beep    = 1'b0;
		m_7ffd    = 8'h00;
		m_eff7    = 8'h00;
		rd_pend   = 1'b0;
		wlo_pend  = 1'b0;
		whi_pend  = 1'b0;
		save_hi   = 8'h00;
		keep_lo   = 8'h00;
		keep_hi   = 8'h00;
		load_table();
		cycle_limit = ops.size() * 4 + RESET_CYCLES + 20;
		repeat (RESET_CYCLES) @(posedge zclk);
		#5 rst_n = 1'b1;
		// reset state
		paging_checks();
		fe_checks(WR);
		check_bit(ide_rd_n, 1'b1, "ide_rd_n after reset");
		check_bit(ide_wr_n, 1'b1, "ide_wr_n after reset");
		check_bit(porthit, 1'b0, "porthit with iorq_n high");
		check_bit(dataout, 1'b0, "dataout with iorq_n high");
		foreach (ops[i])
			run_op(ops[i]);
		$display("Test OK");
		$finish;
	end

endmodule
